// File: compile.f
+incdir+logic
logic/trace_pkg.sv
logic/pc_fifo_if.sv
logic/commit_classifier.sv
logic/pc_fifo.sv
logic/pc_rr_arbiter.sv
logic/commit_tracer.sv
testbench/commit_tracer_props.sv
testbench/tb_commit_tracer.sv

// File: logic/commit_classifier.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_defines.svh"

module commit_classifier (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // commit port entries
  input  logic [`TRACE_NR_PORTS-1:0]                 commit_ack_i,
  input  logic [`TRACE_NR_PORTS-1:0]                 commit_ex_valid_i,
  input  trace_pkg::pc_t [`TRACE_NR_PORTS-1:0]       commit_pc_i,
  input  trace_pkg::cause_t [`TRACE_NR_PORTS-1:0]    commit_cause_i,
  // per port PC queues
  pc_fifo_if.producer                                fifo [`TRACE_NR_PORTS-1:0],
  // trap reporting
  output logic [`TRACE_NR_PORTS-1:0]                 exc_o,
  output logic [`TRACE_NR_PORTS-1:0]                 irq_o,
  output trace_pkg::cause_t [`TRACE_NR_PORTS-1:0]    cause_o,
  output logic                                       overflow_o
);

  import trace_pkg::*;

  logic [`TRACE_NR_PORTS-1:0] retire;
  logic [`TRACE_NR_PORTS-1:0] trap;
  logic [`TRACE_NR_PORTS-1:0] is_irq;
  logic [`TRACE_NR_PORTS-1:0] drop;

  logic [`TRACE_NR_PORTS-1:0] exc_q;
  logic [`TRACE_NR_PORTS-1:0] irq_q;
  cause_t [`TRACE_NR_PORTS-1:0] cause_q;
  logic                       overflow_q;

  // --------------------------------------------------
  // per port sorting
  // --------------------------------------------------
  for (genvar i = 0; i < `TRACE_NR_PORTS; i++) begin : gen_port
    assign retire[i] = commit_ack_i[i] & ~commit_ex_valid_i[i];
    assign trap[i]   = commit_ack_i[i] &  commit_ex_valid_i[i];
    // msb of cause separates interrupts from synchronous exceptions
    assign is_irq[i] = commit_cause_i[i][`TRACE_CAUSE_W-1];

    // push only with room left, otherwise the PC is lost
    assign fifo[i].push    = retire[i] & ~fifo[i].full;
    assign fifo[i].push_pc = commit_pc_i[i];
    assign drop[i]         = retire[i] &  fifo[i].full;

    // cause is held until the next trap on this port
    always_ff @(posedge clk_i) begin
      if (trap[i]) begin
        cause_q[i] <= commit_cause_i[i];
      end
    end
  end

  // --------------------------------------------------
  // trap pulses and sticky overflow
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exc_q      <= '0;
      irq_q      <= '0;
      overflow_q <= 1'b0;
    end else begin
      exc_q <= trap & ~is_irq;
      irq_q <= trap &  is_irq;
      if (|drop) begin
        overflow_q <= 1'b1;
      end
    end
  end

  assign exc_o      = exc_q;
  assign irq_o      = irq_q;
  assign cause_o    = cause_q;
  assign overflow_o = overflow_q;

endmodule

`default_nettype wire

// File: logic/commit_tracer.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_defines.svh"

module commit_tracer (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  // commit ports from the pipeline
  input  logic [`TRACE_NR_PORTS-1:0]                     commit_ack_i,
  input  logic [`TRACE_NR_PORTS-1:0]                     commit_ex_valid_i,
  input  logic [`TRACE_NR_PORTS-1:0][`TRACE_PC_W-1:0]    commit_pc_i,
  input  logic [`TRACE_NR_PORTS-1:0][`TRACE_CAUSE_W-1:0] commit_cause_i,
  // trap reporting, one cycle after the commit
  output logic [`TRACE_NR_PORTS-1:0]                     exc_o,
  output logic [`TRACE_NR_PORTS-1:0]                     irq_o,
  output logic [`TRACE_NR_PORTS-1:0][`TRACE_CAUSE_W-1:0] cause_o,
  output logic                                           overflow_o,
  // ordered PC trace
  output logic                                           trace_valid_o,
  output logic [`TRACE_PC_W-1:0]                         trace_pc_o,
  output logic [trace_pkg::port_idx_w-1:0]               trace_port_o
);

  // one queue link per commit port
  pc_fifo_if fifo_if [`TRACE_NR_PORTS-1:0] ();

  // --------------------------------------------------
  // commit sorting
  // --------------------------------------------------
  commit_classifier i_classifier (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .commit_ack_i      ( commit_ack_i      ),
    .commit_ex_valid_i ( commit_ex_valid_i ),
    .commit_pc_i       ( commit_pc_i       ),
    .commit_cause_i    ( commit_cause_i    ),
    .fifo              ( fifo_if           ),
    .exc_o             ( exc_o             ),
    .irq_o             ( irq_o             ),
    .cause_o           ( cause_o           ),
    .overflow_o        ( overflow_o        )
  );

  // --------------------------------------------------
  // per port PC queues
  // --------------------------------------------------
  for (genvar i = 0; i < `TRACE_NR_PORTS; i++) begin : gen_pc_fifo
    pc_fifo i_pc_fifo (
      .clk_i  ( clk_i      ),
      .rst_ni ( rst_ni     ),
      .fifo   ( fifo_if[i] )
    );
  end

  // --------------------------------------------------
  // round robin drain
  // --------------------------------------------------
  // no back-pressure, one PC leaves per cycle at most
  pc_rr_arbiter i_rr_arbiter (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .fifo          ( fifo_if       ),
    .trace_valid_o ( trace_valid_o ),
    .trace_pc_o    ( trace_pc_o    ),
    .trace_port_o  ( trace_port_o  )
  );

endmodule

`default_nettype wire

// File: logic/pc_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_defines.svh"

module pc_fifo (
  input  logic     clk_i,
  input  logic     rst_ni,
  pc_fifo_if.store fifo
);

  import trace_pkg::*;

  localparam int unsigned ptr_w =
    (`TRACE_FIFO_DEPTH > 1) ? $clog2(`TRACE_FIFO_DEPTH) : 1;
  localparam logic [ptr_w-1:0] last_slot = ptr_w'(`TRACE_FIFO_DEPTH - 1);

  pc_t              mem_q [`TRACE_FIFO_DEPTH];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  fifo_cnt_t        cnt_q;

  // wrap at the last slot, depth need not be a power of two
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == last_slot) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // --------------------------------------------------
  // storage
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (fifo.push) begin
      mem_q[wr_ptr_q] <= fifo.push_pc;
    end
  end

  assign fifo.pop_pc = mem_q[rd_ptr_q];

  // --------------------------------------------------
  // pointers and fill level
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (fifo.push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (fifo.pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // push and pop together leave the count alone
      case ({fifo.push, fifo.pop})
        2'b10:   cnt_q <= cnt_q + fifo_cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - fifo_cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  assign fifo.full  = (cnt_q == fifo_cnt_t'(`TRACE_FIFO_DEPTH));
  assign fifo.empty = (cnt_q == '0);

endmodule

`default_nettype wire

// File: logic/pc_fifo_if.sv
`timescale 1ns/1ps
`default_nettype none

// one port's link between classifier, PC FIFO and arbiter
interface pc_fifo_if;

  import trace_pkg::*;

  // write side
  logic push;
  pc_t  push_pc;
  logic full;

  // read side, pop_pc always shows the oldest entry
  logic empty;
  logic pop;
  pc_t  pop_pc;

  modport producer (
    output push,
    output push_pc,
    input  full
  );

  modport store (
    input  push,
    input  push_pc,
    input  pop,
    output full,
    output empty,
    output pop_pc
  );

  modport consumer (
    output pop,
    input  empty,
    input  pop_pc
  );

endinterface

`default_nettype wire

// File: logic/pc_rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_defines.svh"

module pc_rr_arbiter (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  pc_fifo_if.consumer          fifo [`TRACE_NR_PORTS-1:0],
  // merged trace stream
  output logic                 trace_valid_o,
  output trace_pkg::pc_t       trace_pc_o,
  output trace_pkg::port_idx_t trace_port_o
);

  import trace_pkg::*;

  localparam port_idx_t last_port = port_idx_t'(`TRACE_NR_PORTS - 1);

  logic [`TRACE_NR_PORTS-1:0] empty_vec;
  logic [`TRACE_NR_PORTS-1:0] pop_vec;
  pc_t [`TRACE_NR_PORTS-1:0]  pc_vec;

  logic      gnt_valid;
  port_idx_t gnt_idx;
  port_idx_t rr_ptr_q;

  logic      trace_valid_q;
  pc_t       trace_pc_q;
  port_idx_t trace_port_q;

  // flatten the interface array, it cannot take a variable index
  for (genvar i = 0; i < `TRACE_NR_PORTS; i++) begin : gen_port
    assign empty_vec[i] = fifo[i].empty;
    assign pc_vec[i]    = fifo[i].pop_pc;
    assign fifo[i].pop  = pop_vec[i];
  end

  // --------------------------------------------------
  // grant search
  // --------------------------------------------------
  // first non-empty port at or after rr_ptr_q
  always_comb begin
    int unsigned cand;
    gnt_valid = 1'b0;
    gnt_idx   = '0;
    pop_vec   = '0;
    for (int k = 0; k < `TRACE_NR_PORTS; k++) begin
      cand = int'(rr_ptr_q) + k;
      if (cand >= `TRACE_NR_PORTS) begin
        cand = cand - `TRACE_NR_PORTS;
      end
      if (!gnt_valid && !empty_vec[cand]) begin
        gnt_valid = 1'b1;
        gnt_idx   = port_idx_t'(cand);
      end
    end
    if (gnt_valid) begin
      pop_vec[gnt_idx] = 1'b1;
    end
  end

  // --------------------------------------------------
  // pointer and output stage
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_ptr_q      <= '0;
      trace_valid_q <= 1'b0;
    end else begin
      trace_valid_q <= gnt_valid;
      // pointer only moves on a grant
      if (gnt_valid) begin
        rr_ptr_q <= (gnt_idx == last_port) ? '0 : gnt_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_valid) begin
      trace_pc_q   <= pc_vec[gnt_idx];
      trace_port_q <= gnt_idx;
    end
  end

  assign trace_valid_o = trace_valid_q;
  assign trace_pc_o    = trace_pc_q;
  assign trace_port_o  = trace_port_q;

endmodule

`default_nettype wire

// File: logic/trace_defines.svh
`ifndef TRACE_DEFINES_SVH
`define TRACE_DEFINES_SVH

// --------------------------------------------------
// commit trace sizing
// --------------------------------------------------

// commit ports retiring per cycle
`define TRACE_NR_PORTS 2

// virtual PC width
`define TRACE_PC_W 64

// exception cause width, msb flags an interrupt
`define TRACE_CAUSE_W 64

// entries held per port FIFO
`define TRACE_FIFO_DEPTH 4

`endif

// File: logic/trace_pkg.sv
`default_nettype none

`include "trace_defines.svh"

package trace_pkg;

  // --------------------------------------------------
  // derived widths
  // --------------------------------------------------

  // a single port still needs one index bit
  localparam int unsigned port_idx_w =
    (`TRACE_NR_PORTS > 1) ? $clog2(`TRACE_NR_PORTS) : 1;

  // fill level must reach the full depth value
  localparam int unsigned fifo_cnt_w = $clog2(`TRACE_FIFO_DEPTH + 1);

  // --------------------------------------------------
  // shared vector types
  // --------------------------------------------------

  typedef logic [`TRACE_PC_W-1:0]    pc_t;
  typedef logic [`TRACE_CAUSE_W-1:0] cause_t;
  typedef logic [port_idx_w-1:0]     port_idx_t;
  typedef logic [fifo_cnt_w-1:0]     fifo_cnt_t;

endpackage

`default_nettype wire

// File: testbench/commit_tracer_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_defines.svh"

module commit_tracer_props (
  input logic                       clk_i,
  input logic                       rst_ni,
  input logic [`TRACE_NR_PORTS-1:0] exc_o,
  input logic [`TRACE_NR_PORTS-1:0] irq_o,
  input logic                       trace_valid_o,
  input logic                       overflow_o
);

  // failed assertions so far
  int unsigned fail_cnt = 0;

  // --------------------------------------------------
  // trap reporting
  // --------------------------------------------------
  // a trap is either an exception or an interrupt
  trap_kind_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) (exc_o & irq_o) == '0
  ) else begin
    fail_cnt++;
    $error("exc_o and irq_o high on the same port");
  end

  // --------------------------------------------------
  // trace stream and overflow
  // --------------------------------------------------
  // queues are empty out of reset so nothing is popped at the first edge
  first_cycle_a : assert property (
    @(posedge clk_i) $rose(rst_ni) |=> !trace_valid_o
  ) else begin
    fail_cnt++;
    $error("trace_valid_o high in the first cycle after reset");
  end

  // sticky until reset
  overflow_sticky_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) !$fell(overflow_o)
  ) else begin
    fail_cnt++;
    $error("overflow_o fell while out of reset");
  end

endmodule

bind commit_tracer commit_tracer_props i_props (
  .clk_i         ( clk_i         ),
  .rst_ni        ( rst_ni        ),
  .exc_o         ( exc_o         ),
  .irq_o         ( irq_o         ),
  .trace_valid_o ( trace_valid_o ),
  .overflow_o    ( overflow_o    )
);

`default_nettype wire

// File: testbench/tb_commit_tracer.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_defines.svh"

module tb_commit_tracer;

  import trace_pkg::*;

  localparam int nr_ports    = `TRACE_NR_PORTS;
  localparam int max_rows    = 48;
  localparam int drain_limit = 64;
  localparam cause_t exc_cause = cause_t'(2);
  localparam cause_t irq_cause = {1'b1, {(`TRACE_CAUSE_W-4){1'b0}}, 3'd7};

  logic clk;
  logic rst_n;
  logic [nr_ports-1:0]                     commit_ack;
  logic [nr_ports-1:0]                     commit_ex_valid;
  logic [nr_ports-1:0][`TRACE_PC_W-1:0]    commit_pc;
  logic [nr_ports-1:0][`TRACE_CAUSE_W-1:0] commit_cause;
  logic [nr_ports-1:0]                     exc;
  logic [nr_ports-1:0]                     irq;
  logic [nr_ports-1:0][`TRACE_CAUSE_W-1:0] cause;
  logic                                    overflow;
  logic                                    trace_valid;
  logic [`TRACE_PC_W-1:0]                  trace_pc;
  logic [port_idx_w-1:0]                   trace_port;

  // stimulus table
  // expected trap bits belong to the following cycle
  logic [nr_ports-1:0] tbl_ack [max_rows];
  logic [nr_ports-1:0] tbl_exv [max_rows];
  cause_t              tbl_cause [max_rows][nr_ports];
  pc_t                 tbl_pc [max_rows][nr_ports];
  logic [nr_ports-1:0] tbl_exc [max_rows];
  logic [nr_ports-1:0] tbl_irq [max_rows];
  int                  n_rows;

  // reference model
  pc_t                 model_q [nr_ports][$];
  int                  rr_ptr;
  logic                drop_seen;
  logic                exp_valid;
  pc_t                 exp_pc;
  int                  exp_port;
  logic [nr_ports-1:0] pend_exc;
  logic [nr_ports-1:0] pend_irq;
  int                  pend_row;

  commit_tracer DUT (
    .clk_i             ( clk             ),
    .rst_ni            ( rst_n           ),
    .commit_ack_i      ( commit_ack      ),
    .commit_ex_valid_i ( commit_ex_valid ),
    .commit_pc_i       ( commit_pc       ),
    .commit_cause_i    ( commit_cause    ),
    .exc_o             ( exc             ),
    .irq_o             ( irq             ),
    .cause_o           ( cause           ),
    .overflow_o        ( overflow        ),
    .trace_valid_o     ( trace_valid     ),
    .trace_pc_o        ( trace_pc        ),
    .trace_port_o      ( trace_port      )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      $display("Test failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic add_row(input logic [nr_ports-1:0] ack, input logic [nr_ports-1:0] exv,
                         input cause_t c0, input cause_t c1,
                         input logic [nr_ports-1:0] e_exc, input logic [nr_ports-1:0] e_irq);
    tbl_ack[n_rows]      = ack;
    tbl_exv[n_rows]      = exv;
    tbl_cause[n_rows][0] = c0;
    tbl_cause[n_rows][1] = c1;
    tbl_exc[n_rows]      = e_exc;
    tbl_irq[n_rows]      = e_irq;
    for (int p = 0; p < nr_ports; p++) begin
      tbl_pc[n_rows][p] = pc_t'({$urandom(), $urandom()});
    end
    n_rows++;
  endtask

  // --------------------------------------------------
  // model of one rising edge
  // --------------------------------------------------
  task automatic model_step(input logic [nr_ports-1:0] retire, input int r);
    logic [nr_ports-1:0] full;
    int                  cand;
    for (int p = 0; p < nr_ports; p++) begin
      full[p] = (model_q[p].size() == `TRACE_FIFO_DEPTH);
    end
    // first non-empty queue at or after the pointer
    exp_valid = 1'b0;
    for (int k = 0; k < nr_ports; k++) begin
      cand = (rr_ptr + k) % nr_ports;
      if (!exp_valid && model_q[cand].size() != 0) begin
        exp_valid = 1'b1;
        exp_port  = cand;
      end
    end
    if (exp_valid) begin
      exp_pc = model_q[exp_port].pop_front();
      rr_ptr = (exp_port + 1) % nr_ports;
    end
    for (int p = 0; p < nr_ports; p++) begin
      if (retire[p] && full[p]) begin
        drop_seen = 1'b1;
      end else if (retire[p]) begin
        model_q[p].push_back(tbl_pc[r][p]);
      end
    end
  endtask

  task automatic check_outputs();
    check("trace_valid_o", trace_valid, exp_valid);
    if (exp_valid) begin
      check("trace_pc_o", trace_pc, exp_pc);
      check("trace_port_o", trace_port, exp_port);
    end
    check("exc_o", exc, pend_exc);
    check("irq_o", irq, pend_irq);
    for (int p = 0; p < nr_ports; p++) begin
      if (pend_exc[p] || pend_irq[p]) begin
        check("cause_o", cause[p], tbl_cause[pend_row][p]);
      end
    end
    check("overflow_o", overflow, drop_seen);
  endtask

  // check the last edge, then apply a row (or idle inputs) for the next one
  task automatic run_cycle(input int r, input bit idle);
    @(negedge clk);
    check_outputs();
    commit_ack      = idle ? '0 : tbl_ack[r];
    commit_ex_valid = idle ? '0 : tbl_exv[r];
    for (int p = 0; p < nr_ports; p++) begin
      commit_pc[p]    = idle ? '0 : tbl_pc[r][p];
      commit_cause[p] = idle ? '0 : tbl_cause[r][p];
    end
    pend_exc = idle ? '0 : tbl_exc[r];
    pend_irq = idle ? '0 : tbl_irq[r];
    pend_row = r;
    model_step(commit_ack & ~commit_ex_valid, r);
  endtask

  function automatic bit busy();
    bit b;
    b = exp_valid;
    for (int p = 0; p < nr_ports; p++) begin
      if (model_q[p].size() != 0) begin
        b = 1'b1;
      end
    end
    return b;
  endfunction

  initial begin
    int t;
    rst_n           = 1'b0;
    commit_ack      = '0;
    commit_ex_valid = '0;
    commit_pc       = '0;
    commit_cause    = '0;
    rr_ptr          = 0;
    drop_seen       = 1'b0;
    exp_valid       = 1'b0;
    exp_pc          = '0;
    exp_port        = 0;
    pend_exc        = '0;
    pend_irq        = '0;
    pend_row        = 0;
    n_rows          = 0;
    void'($urandom(32'h4d3));

    // --------------------------------------------------
    // table
    // --------------------------------------------------
    repeat (3) add_row(2'b00, 2'b00, '0, '0, 2'b00, 2'b00);
    add_row(2'b01, 2'b01, exc_cause, '0, 2'b01, 2'b00);
    add_row(2'b10, 2'b10, '0, irq_cause, 2'b00, 2'b10);
    add_row(2'b11, 2'b11, irq_cause, exc_cause, 2'b10, 2'b01);
    // exception valid without ack is ignored
    add_row(2'b00, 2'b11, exc_cause, irq_cause, 2'b00, 2'b00);
    // sparse retires mixed with a trap
    add_row(2'b01, 2'b00, '0, '0, 2'b00, 2'b00);
    add_row(2'b00, 2'b00, '0, '0, 2'b00, 2'b00);
    add_row(2'b10, 2'b00, '0, '0, 2'b00, 2'b00);
    add_row(2'b11, 2'b10, '0, exc_cause, 2'b10, 2'b00);
    add_row(2'b00, 2'b00, '0, '0, 2'b00, 2'b00);
    add_row(2'b01, 2'b00, '0, '0, 2'b00, 2'b00);
    repeat (2) add_row(2'b00, 2'b00, '0, '0, 2'b00, 2'b00);
    // both ports together, arbiter has to alternate
    repeat (3) add_row(2'b11, 2'b00, '0, '0, 2'b00, 2'b00);
    repeat (4) add_row(2'b00, 2'b00, '0, '0, 2'b00, 2'b00);
    // sustained retires overrun the queues
    repeat (12) add_row(2'b11, 2'b00, '0, '0, 2'b00, 2'b00);

    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    for (int r = 0; r < n_rows; r++) begin
      run_cycle(r, 1'b0);
    end

    // drain the queues
    t = 0;
    while (busy()) begin
      if (t == drain_limit) begin
        $display("trace stream did not drain within %0d cycles", drain_limit);
        $display("Test failed");
        $fatal(1, "drain timeout");
      end
      run_cycle(0, 1'b1);
      t++;
    end
    run_cycle(0, 1'b1);
    check("overflow_o", overflow, 1'b1);

    if (DUT.i_props.fail_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
